//--- copper_engine.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// copper engine
// fetches two-word instructions, waits on
// the beam position and issues moves
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module copper_engine (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             enable_i,
    input  logic                             frame_start_i,
    input  logic [copper_pkg::POS_W-1:0]     v_pos_i,
    input  logic [copper_pkg::POS_W-1:0]     h_pos_i,
    output logic [copper_pkg::COPPER_AW-1:0] fetch_addr_o,
    input  copper_pkg::word_t                even_word_i,
    input  copper_pkg::word_t                odd_word_i,
    output logic                             mv_wr_o,
    output logic [copper_pkg::REG_IDX_W-1:0] mv_idx_o,
    output copper_pkg::word_t                mv_data_o,
    output logic                             busy_o
);
    import copper_pkg::*;

    logic [1:0]           state;
    logic [COPPER_AW-1:0] pc;
    copper_insn_t         insn;
    logic                 in_decode;
    logic                 beam_reached;
    logic                 step_done;

    // both halves come back together one cycle after the fetch
    assign insn = {even_word_i, odd_word_i};

    assign in_decode = (state == ST_DECODE);

    // beam is at or past the target position
    assign beam_reached = (v_pos_i > insn.wt.v_pos) ||
                          ((v_pos_i == insn.wt.v_pos) && (h_pos_i >= insn.wt.h_pos));

    // decode ends when the instruction is done
    always_comb begin
        case (insn.wt.op)
            OP_WAIT: step_done = beam_reached;
            default: step_done = 1'b1;
        endcase
    end

    // program counter only moves when leaving decode,
    // so the memory keeps returning the same word during a wait
    assign fetch_addr_o = pc;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state <= ST_IDLE;
            pc    <= '0;
        end else if (!enable_i) begin
            state <= ST_IDLE;
        end else if (frame_start_i) begin
            // a new frame always restarts at instruction 0
            state <= ST_FETCH;
            pc    <= '0;
        end else begin
            case (state)
                ST_FETCH: begin
                    state <= ST_DECODE;
                end
                ST_DECODE: begin
                    if (insn.wt.op == OP_END) begin
                        state <= ST_IDLE;
                    end else if (step_done) begin
                        state <= ST_FETCH;
                        // wraps at 256
                        pc    <= pc + 1'b1;
                    end
                end
                default: begin
                    // idle until the next frame start
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // move write is issued during the decode cycle
    assign mv_wr_o   = in_decode && enable_i && (insn.mv.op == OP_MOVE);
    assign mv_idx_o  = insn.mv.idx;
    assign mv_data_o = insn.mv.data;

    assign busy_o = (state != ST_IDLE);

    // a move write always follows a fetch directly
    a_mv_after_fetch: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        $rose(mv_wr_o) |-> in_decode && ($past(state) == ST_FETCH)
    ) else $error("move write did not follow a fetch");

    // enable must have been held across fetch and decode
    a_mv_enabled: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        mv_wr_o |-> enable_i && $past(enable_i)
    ) else $error("move write while the engine was disabled");

endmodule

//--- copper_host_port.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// copper host write port
// registers host word writes and steers
// them to the even or odd memory half
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module copper_host_port (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             host_wr_i,
    input  logic [copper_pkg::HOST_AW-1:0]   host_addr_i,
    input  copper_pkg::word_t                host_data_i,
    output logic                             wr_even_o,
    output logic                             wr_odd_o,
    output logic [copper_pkg::COPPER_AW-1:0] wr_addr_o,
    output copper_pkg::word_t                wr_data_o
);
    import copper_pkg::*;

    // half strobes, bit 0 of the word address picks the half
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_even_o <= 1'b0;
            wr_odd_o  <= 1'b0;
        end else begin
            wr_even_o <= host_wr_i && !host_addr_i[0];
            wr_odd_o  <= host_wr_i && host_addr_i[0];
        end
    end

    // address and data ride along with the strobes
    always_ff @(posedge clk) begin
        wr_addr_o <= host_addr_i[HOST_AW-1:1];
        wr_data_o <= host_data_i;
    end

    // a host word lands in exactly one half
    a_one_half: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !(wr_even_o && wr_odd_o)
    ) else $error("host port wrote both memory halves at once");

endmodule

//--- copper_mem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// copper program memory, one 16-bit half
// block RAM with a write port and a
// registered read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module copper_mem #(
    parameter int ODD_HALF = 0
) (
    input  logic                             clk,
    input  logic                             wr_en_i,
    input  logic [copper_pkg::COPPER_AW-1:0] wr_addr_i,
    input  copper_pkg::word_t                wr_data_i,
    input  logic [copper_pkg::COPPER_AW-1:0] rd_addr_i,
    output copper_pkg::word_t                rd_data_o
);
    import copper_pkg::*;

    word_t mem [2**COPPER_AW];

    // even half holds the opcode word, so the default decodes as END
    initial begin
        for (int i = 0; i < 2**COPPER_AW; i++) begin
            if (ODD_HALF != 0) begin
                mem[i] = INIT_ODD_WORD;
            end else begin
                mem[i] = INIT_EVEN_WORD;
            end
        end
    end

    // host side write
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // engine side read, one cycle latency
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

//--- copper_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// copper package
// sizes, opcodes, FSM state codes, the
// instruction union and memory defaults
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package copper_pkg;

    // program memory, one instruction per address in each half
    localparam int COPPER_AW = 8;
    // host word address, bit 0 picks the odd half
    localparam int HOST_AW   = COPPER_AW + 1;
    localparam int POS_W     = 10;
    localparam int REG_IDX_W = 4;

    typedef logic [15:0] word_t;

    // opcodes live in bits 31:30
    localparam logic [1:0] OP_NOP  = 2'b00;
    localparam logic [1:0] OP_WAIT = 2'b01;
    localparam logic [1:0] OP_MOVE = 2'b10;
    localparam logic [1:0] OP_END  = 2'b11;

    // engine FSM states
    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_FETCH  = 2'd1;
    localparam logic [1:0] ST_DECODE = 2'd2;

    // wait view: stall until the beam reaches (v_pos, h_pos)
    typedef struct packed {
        logic [1:0]       op;
        logic [POS_W-1:0] v_pos;
        logic [9:0]       rsvd;
        logic [POS_W-1:0] h_pos;
    } wait_insn_t;

    // move view: write data into video register idx
    typedef struct packed {
        logic [1:0]           op;
        logic [9:0]           rsvd;
        logic [REG_IDX_W-1:0] idx;
        word_t                data;
    } move_insn_t;

    // even half gives bits 31:16, odd half gives bits 15:0
    typedef union packed {
        wait_insn_t wt;
        move_insn_t mv;
    } copper_insn_t;

    // empty memory decodes as END at every address
    localparam word_t INIT_EVEN_WORD = {OP_END, 14'h0000};
    localparam word_t INIT_ODD_WORD  = 16'h0000;

endpackage

//--- copper_reg_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// copper video register bank
// 16 registers, a registered write strobe
// out and a host read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module copper_reg_bank (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             mv_wr_i,
    input  logic [copper_pkg::REG_IDX_W-1:0] mv_idx_i,
    input  copper_pkg::word_t                mv_data_i,
    input  logic [copper_pkg::REG_IDX_W-1:0] rd_idx_i,
    output logic                             reg_wr_o,
    output logic [copper_pkg::REG_IDX_W-1:0] reg_idx_o,
    output copper_pkg::word_t                reg_data_o,
    output copper_pkg::word_t                rd_data_o
);
    import copper_pkg::*;

    word_t regs [2**REG_IDX_W];

    // video registers, cleared on reset
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 2**REG_IDX_W; i++) begin
                regs[i] <= '0;
            end
        end else if (mv_wr_i) begin
            regs[mv_idx_i] <= mv_data_i;
        end
    end

    // write strobe to the video side, same edge as the register update
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            reg_wr_o <= 1'b0;
        end else begin
            reg_wr_o <= mv_wr_i;
        end
    end

    always_ff @(posedge clk) begin
        reg_idx_o  <= mv_idx_i;
        reg_data_o <= mv_data_i;
    end

    assign rd_data_o = regs[rd_idx_i];

    // every move costs a fetch and a decode, so writes never come back to back
    a_no_back_to_back: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        reg_wr_o |=> !reg_wr_o
    ) else $error("register writes in two consecutive cycles");

endmodule

//--- copper_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// copper testbench
// beam model, reference model of the
// register writes, stimulus and checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module copper_tb;
    import copper_pkg::*;

    localparam int LINE_LEN     = 16;
    localparam int FRAME_LINES  = 16;
    localparam int FRAME_CYCLES = LINE_LEN * FRAME_LINES;

    typedef struct packed {
        logic                 has_wait;
        logic [POS_W-1:0]     wait_v;
        logic [POS_W-1:0]     wait_h;
        logic [REG_IDX_W-1:0] idx;
        word_t                data;
    } exp_wr_t;

    logic                 clk;
    logic                 rst_n_i;
    logic                 host_wr_i;
    logic [HOST_AW-1:0]   host_addr_i;
    word_t                host_data_i;
    logic                 enable_i;
    logic                 frame_start_i = 1'b0;
    logic [POS_W-1:0]     v_pos_i = '0;
    logic [POS_W-1:0]     h_pos_i = '0;
    logic [REG_IDX_W-1:0] reg_rd_idx_i;
    logic                 reg_wr_o;
    logic [REG_IDX_W-1:0] reg_idx_o;
    word_t                reg_data_o;
    word_t                reg_rd_data_o;
    logic                 busy_o;

    logic [31:0] prog [2**COPPER_AW];
    word_t       shadow [2**REG_IDX_W];
    exp_wr_t     ref_q [$];
    exp_wr_t     exp_q [$];
    string       test_name;
    integer      seed;
    logic [31:0] r;
    int          len;
    int          err_value;
    int          err_other;
    int          writes_seen;

    tb_clock_gen clock_gen_i (.clk_o(clk), .rst_n_o(rst_n_i));

    copper_top dut_i (
        .clk (clk), .rst_n_i (rst_n_i), .host_wr_i (host_wr_i), .host_addr_i (host_addr_i),
        .host_data_i (host_data_i), .enable_i (enable_i), .frame_start_i (frame_start_i),
        .v_pos_i (v_pos_i), .h_pos_i (h_pos_i), .reg_rd_idx_i (reg_rd_idx_i),
        .reg_wr_o (reg_wr_o), .reg_idx_o (reg_idx_o), .reg_data_o (reg_data_o),
        .reg_rd_data_o (reg_rd_data_o), .busy_o (busy_o)
    );

    // beam walks a short line, frame start pulses on the wrap to (0,0)
    always @(posedge clk) begin
        frame_start_i <= 1'b0;
        if (!rst_n_i) begin
            v_pos_i <= '0;
            h_pos_i <= '0;
        end else if (h_pos_i == LINE_LEN - 1) begin
            h_pos_i <= '0;
            if (v_pos_i == FRAME_LINES - 1) begin
                v_pos_i       <= '0;
                frame_start_i <= 1'b1;
            end else begin
                v_pos_i <= v_pos_i + 1'b1;
            end
        end else begin
            h_pos_i <= h_pos_i + 1'b1;
        end
    end

    // instruction encodings, upper word first
    function automatic logic [31:0] enc_move(input logic [3:0] idx, input word_t data);
        return {OP_MOVE, 10'h000, idx, data};
    endfunction

    function automatic logic [31:0] enc_wait(input logic [9:0] v, input logic [9:0] h);
        return {OP_WAIT, v, 10'h000, h};
    endfunction

    function automatic logic [31:0] enc_nop(input word_t filler);
        return {OP_NOP, 14'h0000, filler};
    endfunction

    // walk the program from 0 and list the moves up to END
    function automatic void expected_writes();
        logic [COPPER_AW-1:0] pc;
        logic [31:0]          w;
        exp_wr_t              e;
        pc = '0;
        e  = '0;
        ref_q.delete();
        for (int n = 0; n < 2**COPPER_AW; n++) begin
            w = prog[pc];
            if (w[31:30] == OP_END) break;
            if (w[31:30] == OP_WAIT) begin
                e.has_wait = 1'b1;
                e.wait_v   = w[29:20];
                e.wait_h   = w[9:0];
            end else if (w[31:30] == OP_MOVE) begin
                e.idx  = w[19:16];
                e.data = w[15:0];
                ref_q.push_back(e);
            end
            pc = pc + 1'b1;
        end
    endfunction

    task automatic summary();
        $display("errors: %0d value, %0d other, %0d register writes checked",
                 err_value, err_other, writes_seen);
    endtask

    task automatic abort_timeout(input string what);
        err_other++;
        $display("timeout while waiting for %s in test %s", what, test_name);
        summary();
        $display("*** FAILED ***");
        $finish;
    endtask

    task automatic load_insn(input int addr, input logic [31:0] insn);
        prog[addr] = insn;
        @(posedge clk);
        host_wr_i   <= 1'b1;
        host_addr_i <= {addr[COPPER_AW-1:0], 1'b0};
        host_data_i <= insn[31:16];
        @(posedge clk);
        host_addr_i <= {addr[COPPER_AW-1:0], 1'b1};
        host_data_i <= insn[15:0];
        @(posedge clk);
        host_wr_i <= 1'b0;
    endtask

    // copy the reference list once per frame, up to limit entries each
    task automatic queue_frames(input int frames, input int limit);
        for (int f = 0; f < frames; f++) begin
            for (int k = 0; k < ref_q.size() && k < limit; k++) begin
                exp_q.push_back(ref_q[k]);
                shadow[ref_q[k].idx] = ref_q[k].data;
            end
        end
    endtask

    task automatic wait_frame_start();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > FRAME_CYCLES + 8) abort_timeout("frame start");
        end while (!frame_start_i);
    endtask

    task automatic wait_busy(input logic level, input int limit, input string what);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > limit) abort_timeout(what);
        end while (busy_o !== level);
    endtask

    task automatic wait_strobe();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > FRAME_CYCLES) abort_timeout("a register write");
        end while (!reg_wr_o);
    endtask

    task automatic check_drained();
        @(negedge clk);
        assert (exp_q.size() == 0) else begin
            $display("%0d expected register writes never came in test %s",
                     exp_q.size(), test_name);
            err_other++;
            exp_q.delete();
        end
    endtask

    task automatic run_frames(input int frames);
        @(posedge clk);
        enable_i <= 1'b1;
        for (int f = 0; f < frames; f++) begin
            wait_frame_start();
            wait_busy(1'b1, 4, "engine start");
            wait_busy(1'b0, FRAME_CYCLES, "END");
        end
        @(posedge clk);
        enable_i <= 1'b0;
        check_drained();
    endtask

    task automatic check_regs();
        for (int i = 0; i < 2**REG_IDX_W; i++) begin
            @(posedge clk);
            reg_rd_idx_i <= REG_IDX_W'(i);
            @(negedge clk);
            assert (reg_rd_data_o == shadow[i]) else begin
                $display("[FAIL] %s reg %0d: expected %h, actual %h",
                         test_name, i, shadow[i], reg_rd_data_o);
                err_value++;
            end
        end
    endtask

    // every strobe is matched in order, and checked against the last WAIT
    always @(negedge clk) begin : compare_writes
        exp_wr_t e;
        if (rst_n_i && reg_wr_o) begin
            assert (exp_q.size() > 0) else begin
                $display("unexpected register write to index %0d in test %s",
                         reg_idx_o, test_name);
                err_other++;
            end
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                writes_seen++;
                assert ({reg_idx_o, reg_data_o} == {e.idx, e.data}) else begin
                    $display("[FAIL] %s write: expected r%0d=%h, actual r%0d=%h",
                             test_name, e.idx, e.data, reg_idx_o, reg_data_o);
                    err_value++;
                end
                if (e.has_wait) begin
                    assert ((v_pos_i > e.wait_v) ||
                            (v_pos_i == e.wait_v && h_pos_i >= e.wait_h)) else begin
                        $display("write at beam (%0d,%0d) before WAIT (%0d,%0d) in test %s",
                                 v_pos_i, h_pos_i, e.wait_v, e.wait_h, test_name);
                        err_other++;
                    end
                end
            end
        end
    end

    initial begin
        host_wr_i    = 1'b0;
        host_addr_i  = '0;
        host_data_i  = '0;
        enable_i     = 1'b0;
        reg_rd_idx_i = '0;
        seed         = 32'hbb1a_7248;
        err_value    = 0;
        err_other    = 0;
        writes_seen  = 0;
        test_name    = "reset";
        for (int i = 0; i < 2**COPPER_AW; i++) prog[i] = {OP_END, 30'h0};
        for (int i = 0; i < 2**REG_IDX_W; i++) shadow[i] = '0;

        for (int n = 0; !rst_n_i; n++) begin
            @(negedge clk);
            if (n > 20) abort_timeout("reset release");
        end
        @(negedge clk);
        assert (!reg_wr_o && !busy_o) else begin
            $display("register write or busy still high after reset");
            err_other++;
        end

        test_name = "unloaded";
        expected_writes();
        queue_frames(1, 256);
        run_frames(1);
        check_regs();

        test_name = "moves";
        for (int a = 0; a < 8; a++) begin
            load_insn(a, enc_move(4'((a * 3) % 5), 16'(16'h1000 + a * 16'h0111)));
        end
        load_insn(8, {OP_END, 30'h0});
        expected_writes();
        queue_frames(1, 256);
        run_frames(1);
        check_regs();

        test_name = "wait";
        load_insn(0, enc_move(4'd0, 16'ha0a0));
        load_insn(1, enc_wait(10'd3, 10'd5));
        load_insn(2, enc_move(4'd4, 16'hb4b4));
        load_insn(3, enc_move(4'd5, 16'hc5c5));
        load_insn(4, enc_wait(10'd6, 10'd12));
        load_insn(5, enc_move(4'd6, 16'hd6d6));
        load_insn(6, {OP_END, 30'h0});
        expected_writes();
        queue_frames(1, 256);
        run_frames(1);
        check_regs();

        // the move after END must never run
        test_name = "end_nop";
        load_insn(0, enc_move(4'd7, 16'h7777));
        load_insn(1, enc_nop(16'hbeef));
        load_insn(2, enc_move(4'd8, 16'h8888));
        load_insn(3, {OP_END, 30'h0});
        load_insn(4, enc_move(4'd9, 16'h9999));
        expected_writes();
        queue_frames(2, 256);
        run_frames(2);
        check_regs();

        test_name = "random";
        for (int p = 0; p < 3; p++) begin
            r = $random(seed);
            len = 6 + int'(r % 7);
            for (int a = 0; a < len - 1; a++) begin
                r = $random(seed);
                case (r[1:0])
                    2'd0, 2'd1: load_insn(a, enc_move(r[7:4], r[31:16]));
                    2'd2:       load_insn(a, enc_wait(10'(r[15:8] % 11), 10'(r[23:16] % 16)));
                    default:    load_insn(a, enc_nop(r[31:16]));
                endcase
            end
            load_insn(len - 1, {OP_END, 30'h0});
            expected_writes();
            queue_frames(2, 256);
            run_frames(2);
            check_regs();
        end

        // drop enable while the engine waits on a far beam position
        test_name = "disable";
        load_insn(0, enc_move(4'd1, 16'h1111));
        load_insn(1, enc_wait(10'd8, 10'd0));
        load_insn(2, enc_move(4'd2, 16'h2222));
        load_insn(3, enc_move(4'd3, 16'h3333));
        load_insn(4, {OP_END, 30'h0});
        expected_writes();
        queue_frames(1, 1);
        @(posedge clk);
        enable_i <= 1'b1;
        wait_frame_start();
        wait_strobe();
        @(posedge clk);
        enable_i <= 1'b0;
        wait_busy(1'b0, 2, "busy low after disable");
        // past the WAIT position and the next frame start, still no writes
        repeat (FRAME_CYCLES) @(negedge clk);
        check_drained();

        test_name = "reload";
        load_insn(0, enc_move(4'd10, 16'haaaa));
        load_insn(1, enc_wait(10'd2, 10'd3));
        load_insn(2, enc_move(4'd11, 16'hbbbb));
        load_insn(3, {OP_END, 30'h0});
        expected_writes();
        queue_frames(1, 256);
        run_frames(1);
        check_regs();

        summary();
        if (err_value == 0 && err_other == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- copper_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// copper top level
// host port, program memory halves,
// engine and video register bank
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module copper_top (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             host_wr_i,
    input  logic [copper_pkg::HOST_AW-1:0]   host_addr_i,
    input  copper_pkg::word_t                host_data_i,
    input  logic                             enable_i,
    input  logic                             frame_start_i,
    input  logic [copper_pkg::POS_W-1:0]     v_pos_i,
    input  logic [copper_pkg::POS_W-1:0]     h_pos_i,
    input  logic [copper_pkg::REG_IDX_W-1:0] reg_rd_idx_i,
    output logic                             reg_wr_o,
    output logic [copper_pkg::REG_IDX_W-1:0] reg_idx_o,
    output copper_pkg::word_t                reg_data_o,
    output copper_pkg::word_t                reg_rd_data_o,
    output logic                             busy_o
);
    import copper_pkg::*;

    logic                 mem_wr_even;
    logic                 mem_wr_odd;
    logic [COPPER_AW-1:0] mem_wr_addr;
    word_t                mem_wr_data;
    logic [COPPER_AW-1:0] fetch_addr;
    word_t                even_word;
    word_t                odd_word;
    logic                 mv_wr;
    logic [REG_IDX_W-1:0] mv_idx;
    word_t                mv_data;

    copper_host_port host_port_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .host_wr_i   (host_wr_i),
        .host_addr_i (host_addr_i),
        .host_data_i (host_data_i),
        .wr_even_o   (mem_wr_even),
        .wr_odd_o    (mem_wr_odd),
        .wr_addr_o   (mem_wr_addr),
        .wr_data_o   (mem_wr_data)
    );

    // upper instruction word
    copper_mem #(.ODD_HALF(0)) mem_even_i (
        .clk       (clk),
        .wr_en_i   (mem_wr_even),
        .wr_addr_i (mem_wr_addr),
        .wr_data_i (mem_wr_data),
        .rd_addr_i (fetch_addr),
        .rd_data_o (even_word)
    );

    // lower instruction word
    copper_mem #(.ODD_HALF(1)) mem_odd_i (
        .clk       (clk),
        .wr_en_i   (mem_wr_odd),
        .wr_addr_i (mem_wr_addr),
        .wr_data_i (mem_wr_data),
        .rd_addr_i (fetch_addr),
        .rd_data_o (odd_word)
    );

    copper_engine engine_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .enable_i      (enable_i),
        .frame_start_i (frame_start_i),
        .v_pos_i       (v_pos_i),
        .h_pos_i       (h_pos_i),
        .fetch_addr_o  (fetch_addr),
        .even_word_i   (even_word),
        .odd_word_i    (odd_word),
        .mv_wr_o       (mv_wr),
        .mv_idx_o      (mv_idx),
        .mv_data_o     (mv_data),
        .busy_o        (busy_o)
    );

    copper_reg_bank reg_bank_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .mv_wr_i    (mv_wr),
        .mv_idx_i   (mv_idx),
        .mv_data_i  (mv_data),
        .rd_idx_i   (reg_rd_idx_i),
        .reg_wr_o   (reg_wr_o),
        .reg_idx_o  (reg_idx_o),
        .reg_data_o (reg_data_o),
        .rd_data_o  (reg_rd_data_o)
    );

endmodule

//--- project.f
copper_pkg.sv
copper_mem.sv
copper_host_port.sv
copper_engine.sv
copper_reg_bank.sv
copper_top.sv
tb_clock_gen.sv
copper_tb.sv

//--- tb_clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset
// 20 ns clock, reset low for 5 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD = 10,
    parameter int RST_CYCLES  = 5
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // release on a rising edge, as the design resets synchronously
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule
